// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module mipsCore_tb \
		-f list.f --Mdir obj_dir -o simv
	./obj_dir/simv +verilator+error+limit+100 | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: decodeStage.sv
`timescale 1ns/1ps

module decodeStage import mipsPkg::*; (
    input  logic    CLK,
    input  logic    rstN,
    input  logic    stall,
    input  logic    flush,
    input  wordT    instrId,
    input  wordT    pcPlus4Id,
    input  ctrlT    ctrl,
    resultBus.consumer wbBus,                // Register file write port
    output ctrlT    exCtrl,
    output wordT    exA,
    output wordT    exB,
    output wordT    exImm,
    output wordT    exPcPlus4,
    output regAddrT exRs,
    output regAddrT exRt,
    output regAddrT exDest,
    output logic    exMemRead
);

    regAddrT rs;
    regAddrT rt;
    regAddrT rd;
    regAddrT dest;
    wordT    readA;
    wordT    readB;
    wordT    imm;
    wordT    regs [2**REG_W];

    assign rs = instrId[25:21];
    assign rt = instrId[20:16];
    assign rd = instrId[15:11];
    assign dest = ctrl.regDstRd ? rd : rt;

    always_ff @(posedge CLK) begin
        if (wbBus.regWrite) regs[wbBus.dest] <= wbBus.value;
    end

    // $0 reads zero; same-cycle write is passed through
    assign readA = (rs == '0) ? '0 :
                   (wbBus.regWrite && wbBus.dest == rs) ? wbBus.value : regs[rs];
    assign readB = (rt == '0) ? '0 :
                   (wbBus.regWrite && wbBus.dest == rt) ? wbBus.value : regs[rt];

    assign imm = ctrl.zeroExt ? {{(DATA_W-16){1'b0}}, instrId[15:0]}
                              : {{(DATA_W-16){instrId[15]}}, instrId[15:0]};

    ////////////////////////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (!rstN || stall || flush) begin
            exCtrl <= '0;                    // Bubble
        end else begin
            exCtrl          <= ctrl;
            exCtrl.regWrite <= ctrl.regWrite && (dest != '0);   // $0 is never written
        end
    end

    always_ff @(posedge CLK) begin
        exA       <= readA;
        exB       <= readB;
        exImm     <= imm;
        exPcPlus4 <= pcPlus4Id;
        exRs      <= rs;
        exRt      <= rt;
        exDest    <= dest;
    end

    assign exMemRead = exCtrl.memRead;       // Load-use check in control

endmodule

// File: executeStage.sv
`timescale 1ns/1ps

module executeStage import mipsPkg::*; (
    input  logic    CLK,
    input  logic    rstN,
    input  ctrlT    exCtrl,
    input  wordT    exA,                     // rs from the register file
    input  wordT    exB,                     // rt from the register file
    input  wordT    exImm,
    input  wordT    exPcPlus4,
    input  regAddrT exDest,
    input  fwdSelT  fwdSelA,
    input  fwdSelT  fwdSelB,
    resultBus.consumer wbBus,
    resultBus.producer memBus,               // EX/MEM register
    output logic    memWrite,
    output wordT    storeData,
    output logic    branchTaken,
    output wordT    branchTarget
);

    wordT opA;
    wordT opB;
    wordT aluB;
    wordT aluRes;
    logic operandsEq;

    ////////////////////////////////////////////////////////////
    // Forwarding and operand select
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (fwdSelA)
            FWD_MEM: opA = memBus.value;     // ALU result one stage ahead
            FWD_WB:  opA = wbBus.value;
            default: opA = exA;
        endcase
        case (fwdSelB)
            FWD_MEM: opB = memBus.value;
            FWD_WB:  opB = wbBus.value;
            default: opB = exB;
        endcase
    end

    assign aluB = exCtrl.aluSrcImm ? exImm : opB;

    always_comb begin
        case (exCtrl.aluOp)
            ALU_SUB: aluRes = opA - aluB;
            ALU_AND: aluRes = opA & aluB;
            ALU_OR:  aluRes = opA | aluB;
            ALU_SLT: aluRes = {{(DATA_W-1){1'b0}}, $signed(opA) < $signed(aluB)};
            default: aluRes = opA + aluB;    // addu, addiu, lw, sw
        endcase
    end

    // Branch resolves here, two younger slots get flushed
    assign operandsEq   = (opA == opB);
    assign branchTaken  = exCtrl.branch && (operandsEq ^ exCtrl.branchNe);
    assign branchTarget = exPcPlus4 + {exImm[DATA_W-3:0], 2'b00};

    ////////////////////////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            memBus.regWrite <= 1'b0;
            memBus.memRead  <= 1'b0;
            memWrite        <= 1'b0;
        end else begin
            memBus.regWrite <= exCtrl.regWrite;
            memBus.memRead  <= exCtrl.memRead;
            memWrite        <= exCtrl.memWrite;
        end
    end

    always_ff @(posedge CLK) begin
        memBus.dest  <= exDest;
        memBus.value <= aluRes;              // Address for lw/sw
        storeData    <= opB;                 // Forwarded rt
    end

endmodule

// File: fetchStage.sv
`timescale 1ns/1ps

module fetchStage import mipsPkg::*; (
    input  logic               CLK,
    input  logic               rstN,
    input  logic               stall,
    input  logic               flush,
    input  logic               branchTaken,
    input  wordT               branchTarget,
    input  logic               imemWe,
    input  logic [IMEM_AW-1:0] imemAddr,
    input  wordT               imemData,
    output wordT               instrId,      // IF/ID instruction
    output wordT               pcPlus4Id     // IF/ID return address for branch target
);

    wordT pc;
    wordT pcPlus4;
    wordT pcNext;
    wordT imem [2**IMEM_AW];                 // Word addressed

    assign pcPlus4 = pc + 32'd4;
    assign pcNext  = branchTaken ? branchTarget : pcPlus4;

    // Program load port, open in any cycle
    always_ff @(posedge CLK) begin
        if (imemWe) imem[imemAddr] <= imemData;
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc      <= '0;
            instrId <= NOP_INSTR;
        end else begin
            if (flush || !stall) pc <= pcNext;   // Redirect beats hold
            if (flush) instrId <= NOP_INSTR;     // Drop the wrong-path fetch
            else if (!stall) instrId <= imem[pc[IMEM_AW+1:2]];
        end
    end

    // Payload only
    always_ff @(posedge CLK) begin
        if (!stall) pcPlus4Id <= pcPlus4;
    end

endmodule

// File: list.f
mipsPkg.sv
mipsIf.sv
pipeControl.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
mipsCore.sv
mipsCore_checker.sv
mipsCore_tb.sv

// File: memoryStage.sv
`timescale 1ns/1ps

module memoryStage import mipsPkg::*; (
    input  logic CLK,
    input  logic rstN,
    resultBus.consumer memBus,               // ALU result is the address
    input  logic memWrite,
    input  wordT storeData,
    resultBus.producer wbBus                 // MEM/WB register
);

    logic [DMEM_AW-1:0] dmemAddr;
    wordT               loadData;
    wordT               wbData;
    wordT               dmem [2**DMEM_AW];

    // Byte offset dropped, upper bits wrap
    assign dmemAddr = memBus.value[DMEM_AW+1:2];
    assign loadData = dmem[dmemAddr];        // Async read

    always_ff @(posedge CLK) begin
        if (memWrite) dmem[dmemAddr] <= storeData;
    end

    assign wbData = memBus.memRead ? loadData : memBus.value;

    ////////////////////////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (!rstN) wbBus.regWrite <= 1'b0;
        else       wbBus.regWrite <= memBus.regWrite;
    end

    always_ff @(posedge CLK) begin
        wbBus.dest  <= memBus.dest;
        wbBus.value <= wbData;
    end

    assign wbBus.memRead = 1'b0;             // Load data already resolved

endmodule

// File: mipsCore.sv
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; (
    input  logic               CLK,
    input  logic               rstN,
    input  logic               imemWe,       // Program load port
    input  logic [IMEM_AW-1:0] imemAddr,
    input  wordT               imemData,
    output wordT               outVal,       // Writeback observation
    output regAddrT            regAddr,
    output logic               regWrite
);

    ////////////////////////////////////////////////////////////
    // Inter-stage wiring
    ////////////////////////////////////////////////////////////
    logic    stall;
    logic    flush;
    ctrlT    ctrl;
    fwdSelT  fwdSelA;
    fwdSelT  fwdSelB;
    logic    branchTaken;
    wordT    branchTarget;
    wordT    instrId;
    wordT    pcPlus4Id;
    ctrlT    exCtrl;
    wordT    exA;
    wordT    exB;
    wordT    exImm;
    wordT    exPcPlus4;
    regAddrT exRs;
    regAddrT exRt;
    regAddrT exDest;
    logic    exMemRead;
    logic    memWrite;
    wordT    storeData;

    resultBus memBus ();                     // EX/MEM register contents
    resultBus wbBus ();                      // MEM/WB register contents

    pipeControl u_ctrl (.instrId(instrId), .exRs(exRs), .exRt(exRt), .exMemRead(exMemRead),
        .branchTaken(branchTaken), .memBus(memBus), .wbBus(wbBus), .ctrl(ctrl),
        .stall(stall), .flush(flush), .fwdSelA(fwdSelA), .fwdSelB(fwdSelB));

    fetchStage u_fetch (.CLK(CLK), .rstN(rstN), .stall(stall), .flush(flush),
        .branchTaken(branchTaken), .branchTarget(branchTarget), .imemWe(imemWe),
        .imemAddr(imemAddr), .imemData(imemData), .instrId(instrId), .pcPlus4Id(pcPlus4Id));

    decodeStage u_decode (.CLK(CLK), .rstN(rstN), .stall(stall), .flush(flush),
        .instrId(instrId), .pcPlus4Id(pcPlus4Id), .ctrl(ctrl), .wbBus(wbBus),
        .exCtrl(exCtrl), .exA(exA), .exB(exB), .exImm(exImm), .exPcPlus4(exPcPlus4),
        .exRs(exRs), .exRt(exRt), .exDest(exDest), .exMemRead(exMemRead));

    executeStage u_execute (.CLK(CLK), .rstN(rstN), .exCtrl(exCtrl), .exA(exA), .exB(exB),
        .exImm(exImm), .exPcPlus4(exPcPlus4), .exDest(exDest), .fwdSelA(fwdSelA),
        .fwdSelB(fwdSelB), .wbBus(wbBus), .memBus(memBus), .memWrite(memWrite),
        .storeData(storeData), .branchTaken(branchTaken), .branchTarget(branchTarget));

    memoryStage u_memory (.CLK(CLK), .rstN(rstN), .memBus(memBus), .memWrite(memWrite),
        .storeData(storeData), .wbBus(wbBus));

    // Observation ports straight off MEM/WB
    assign outVal   = wbBus.value;
    assign regAddr  = wbBus.dest;
    assign regWrite = wbBus.regWrite;

endmodule

// File: mipsCore_checker.sv
`timescale 1ns/1ps

module mipsCore_checker import mipsPkg::*; (
    input logic    CLK,
    input logic    rstN,
    input logic    regWrite,
    input regAddrT regAddr,
    input wordT    outVal,
    input logic    stall,
    input logic    flush,
    input ctrlT    exCtrl                    // ID/EX control fields
);

    int failCount = 0;                       // Tally for the end-of-run summary

    // r0 writes are dropped in decode
    noZeroDest: assert property (@(posedge CLK) disable iff (!rstN)
        regWrite |-> regAddr != '0)
        else begin
            failCount++;
            $error("writeback reported to register 0");
        end

    // Held or flushed decode slot enters EX as a bubble
    bubbleOnHold: assert property (@(posedge CLK) disable iff (!rstN)
        (stall || flush) |=> exCtrl == '0)
        else begin
            failCount++;
            $error("ID/EX did not take a bubble after a stall or flush");
        end

    knownResult: assert property (@(posedge CLK) disable iff (!rstN)
        regWrite |-> !$isunknown(outVal))
        else begin
            failCount++;
            $error("writeback value has unknown bits");
        end

endmodule

bind mipsCore mipsCore_checker u_checker (
    .CLK(CLK),
    .rstN(rstN),
    .regWrite(regWrite),
    .regAddr(regAddr),
    .outVal(outVal),
    .stall(stall),
    .flush(flush),
    .exCtrl(exCtrl)
);

// File: mipsCore_tb.sv
`timescale 1ns/1ps

module mipsCore_tb import mipsPkg::*; ();

    localparam int IMEM_WORDS   = 2**IMEM_AW;
    localparam int NUM_PROGS    = 3;
    localparam int PROG_INSTRS  = 40;            // Random body of each program
    localparam int RESET_CYCLES = 5;
    localparam int RUN_CYCLES   = 150;           // Per program, from reset release
    localparam int DRAIN_CYCLES = 8;             // Quiet time to catch stray writes
    localparam int PIPE_DEPTH   = 4;             // Edges from first fetch to writeback
    localparam int TIMEOUT_CYCLES =
        NUM_PROGS * (IMEM_WORDS + RESET_CYCLES + RUN_CYCLES + DRAIN_CYCLES + 10);
    localparam logic [31:0] SEED = 32'd19;

    logic               CLK;
    logic               rstN;
    logic               imemWe;
    logic [IMEM_AW-1:0] imemAddr;
    wordT               imemData;
    wordT               outVal;
    regAddrT            regAddr;
    logic               regWrite;

    wordT        prog [IMEM_WORDS];              // Image written through the load port
    regAddrT     expDest [$];                    // Expected writes in program order
    wordT        expVal [$];
    int          expIdx = 0;
    logic [31:0] rngState;
    logic        monitorOn = 1'b0;
    int          cycleCount = 0;
    int          runCycles = 0;                  // Edges since reset release
    int          writesChecked = 0;
    int          mismatches = 0;
    int          otherErrors = 0;

    mipsCore u_dut (
        .CLK(CLK),
        .rstN(rstN),
        .imemWe(imemWe),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .outVal(outVal),
        .regAddr(regAddr),
        .regWrite(regWrite)
    );

    always #10 CLK = ~CLK;                       // 20 ns period

    ////////////////////////////////////////////////////////////
    // Random numbers and instruction encoding
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // Only r0..r7 are used, all seeded up front
    function automatic regAddrT randReg();
        logic [31:0] v;
        v = nextRand();
        return {2'b00, v[2:0]};
    endfunction

    // Word index idx in bits 9:2, random wrap bits above, junk byte offset below
    function automatic logic [15:0] memOffset(input logic [2:0] idx, input logic [31:0] v);
        return {v[15:10], 5'b00000, idx, v[1:0]};
    endfunction

    function automatic wordT encodeR(input regAddrT rs, input regAddrT rt, input regAddrT rd,
                                     input logic [5:0] fn);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic wordT encodeI(input logic [5:0] op, input regAddrT rs, input regAddrT rt,
                                     input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic buildProgram(output int len);
        logic [31:0] v;
        logic [5:0]  fn;
        int          a;
        int          n;
        int          kind;
        n = 0;
        for (a = 0; a < IMEM_WORDS; a++) prog[a] = NOP_INSTR;
        for (a = 1; a < 8; a++) begin            // Seed r1..r7
            v = nextRand();
            prog[n] = encodeI(OP_ORI, 5'd0, 5'(a), v[15:0]);
            n++;
        end
        for (a = 0; a < 8; a++) begin            // Define every data word a load can hit
            v = nextRand();
            prog[n] = encodeI(OP_SW, 5'd0, 5'(a), memOffset(3'(a), v));
            n++;
        end
        for (a = 0; a < PROG_INSTRS; a++) begin
            v = nextRand();
            kind = v % 10;
            case (kind)
                4: prog[n] = encodeI(OP_ADDIU, randReg(), randReg(), v[31:16]);
                5: prog[n] = encodeI(OP_ORI, randReg(), randReg(), v[31:16]);
                6: prog[n] = encodeI(OP_LW, 5'd0, randReg(), memOffset(v[18:16], v));
                7: prog[n] = encodeI(OP_SW, 5'd0, randReg(), memOffset(v[18:16], v));
                8: prog[n] = encodeI(v[4] ? OP_BNE : OP_BEQ, randReg(), randReg(),
                                     {14'd0, v[17:16]});   // Forward by 0..3
                default: begin
                    case ((v >> 8) % 5)
                        0: fn = FN_ADDU;
                        1: fn = FN_SUBU;
                        2: fn = FN_AND;
                        3: fn = FN_OR;
                        default: fn = FN_SLT;
                    endcase
                    prog[n] = encodeR(randReg(), randReg(), randReg(), fn);
                end
            endcase
            n++;
        end
        len = n;
    endtask

    ////////////////////////////////////////////////////////////
    // Sequential ISA model
    ////////////////////////////////////////////////////////////
    task automatic runModel(input int len);
        wordT       regs [32];
        wordT       mem [2**DMEM_AW];
        wordT       instr;
        wordT       a;
        wordT       b;
        wordT       imm;
        wordT       res;
        logic [5:0] op;
        regAddrT    wd;
        logic       we;
        int         pc;
        expDest.delete();
        expVal.delete();
        foreach (regs[i]) regs[i] = '0;
        foreach (mem[i]) mem[i] = '0;
        pc = 0;                                  // Word index
        while (pc < len) begin
            instr = prog[pc];
            op    = instr[31:26];
            a     = regs[instr[25:21]];
            b     = regs[instr[20:16]];
            imm   = {{16{instr[15]}}, instr[15:0]};
            wd    = instr[20:16];
            we    = 1'b1;
            res   = '0;
            pc++;
            case (op)
                OP_RTYPE: begin
                    wd = instr[15:11];
                    case (instr[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: we = 1'b0;
                    endcase
                end
                OP_ADDIU: res = a + imm;
                OP_ORI:   res = a | {16'h0000, instr[15:0]};
                OP_LW: begin
                    res = a + imm;
                    res = mem[res[DMEM_AW+1:2]];
                end
                OP_SW: begin
                    res = a + imm;
                    mem[res[DMEM_AW+1:2]] = b;
                    we = 1'b0;
                end
                OP_BEQ, OP_BNE: begin
                    if ((a == b) != (op == OP_BNE)) pc = pc + int'(imm);
                    we = 1'b0;
                end
                default: we = 1'b0;
            endcase
            if (we && wd != '0) begin            // r0 stays zero
                regs[wd] = res;
                expDest.push_back(wd);
                expVal.push_back(res);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Program load and run
    ////////////////////////////////////////////////////////////
    task automatic loadProgram();
        int a;
        @(posedge CLK);
        monitorOn = 1'b0;
        expIdx    = 0;
        rstN     <= 1'b0;
        for (a = 0; a < IMEM_WORDS; a++) begin   // Whole memory, clears the old program
            imemWe   <= 1'b1;
            imemAddr <= IMEM_AW'(a);
            imemData <= prog[a];
            @(posedge CLK);
        end
        imemWe <= 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        rstN     <= 1'b1;
        monitorOn = 1'b1;
    endtask

    task automatic runProgram(input int p);
        int waited;
        waited = 0;
        while (expIdx < expDest.size() && waited < RUN_CYCLES) begin
            @(posedge CLK);
            waited++;
        end
        repeat (DRAIN_CYCLES) @(posedge CLK);
        if (expIdx < expDest.size()) begin
            otherErrors++;
            $display("program %0d stopped after %0d of %0d expected register writes",
                     p, expIdx, expDest.size());
        end
    endtask

    // Writeback monitor, sampled away from the active edge
    always @(negedge CLK) begin
        if (monitorOn && regWrite === 1'b1) begin
            if (runCycles < PIPE_DEPTH) begin
                otherErrors++;
                $display("write to r%0d seen %0d cycles after reset, before any writeback",
                         regAddr, runCycles);
            end
            if (regAddr == '0) begin
                otherErrors++;
                $display("write to register 0 reported at %0t", $time);
            end
            if (expIdx >= expDest.size()) begin
                otherErrors++;
                $display("unexpected write r%0d = %h at %0t", regAddr, outVal, $time);
            end else begin
                if (regAddr !== expDest[expIdx] || outVal !== expVal[expIdx]) begin
                    mismatches++;
                    $display("mismatch at %0t: write %0d expected r%0d = %h, got r%0d = %h",
                             $time, expIdx, expDest[expIdx], expVal[expIdx], regAddr, outVal);
                end
                writesChecked++;
                expIdx++;
            end
        end
    end

    // Cycle counting and run limit
    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        runCycles  <= rstN ? runCycles + 1 : 0;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        int p;
        int progLen;
        CLK      = 1'b0;
        rstN     = 1'b0;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        rngState = SEED;
        for (p = 0; p < NUM_PROGS; p++) begin
            buildProgram(progLen);
            runModel(progLen);
            loadProgram();
            runProgram(p);
        end
        $display("checked %0d writes, %0d mismatches, %0d other errors, %0d assertion failures",
                 writesChecked, mismatches, otherErrors, u_dut.u_checker.failCount);
        if (mismatches == 0 && otherErrors == 0 && u_dut.u_checker.failCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: mipsIf.sv
`timescale 1ns/1ps

// Writeback-bound result of one pipeline stage
interface resultBus import mipsPkg::*; ();

    logic    regWrite;                     // Instruction writes a register
    logic    memRead;                      // Value is still an address, data not loaded yet
    regAddrT dest;                         // Destination register
    wordT    value;                        // Result or writeback data

    // Stage register that owns the bus
    modport producer (
        output regWrite,
        output memRead,
        output dest,
        output value
    );

    // Hazard logic, forwarding and the next stage
    modport consumer (
        input regWrite,
        input memRead,
        input dest,
        input value
    );

endinterface

// File: mipsPkg.sv
package mipsPkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////
    localparam int DATA_W  = 32;           // Datapath width
    localparam int REG_W   = 5;            // 32 registers
    localparam int IMEM_AW = 8;            // 256 instruction words
    localparam int DMEM_AW = 8;            // 256 data words

    typedef logic [DATA_W-1:0] wordT;
    typedef logic [REG_W-1:0]  regAddrT;

    // All-zero word decodes to no control, used as NOP
    localparam wordT NOP_INSTR = '0;

    // Opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;

    // R-type function codes
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} aluOpT;

    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwdSelT;

    // Decoded control, travels with the instruction down to EX
    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  aluSrcImm;                  // Immediate replaces rt
        logic  zeroExt;                    // ori only
        logic  regDstRd;                   // Dest is rd, else rt
        logic  branch;
        logic  branchNe;                   // bne when set with branch
        aluOpT aluOp;
    } ctrlT;

endpackage

// File: pipeControl.sv
`timescale 1ns/1ps

module pipeControl import mipsPkg::*; (
    input  wordT    instrId,                 // Instruction in decode
    input  regAddrT exRs,
    input  regAddrT exRt,                    // Also the load destination
    input  logic    exMemRead,
    input  logic    branchTaken,
    resultBus.consumer memBus,
    resultBus.consumer wbBus,
    output ctrlT    ctrl,
    output logic    stall,
    output logic    flush,
    output fwdSelT  fwdSelA,
    output fwdSelT  fwdSelB
);

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddrT    idRs;
    regAddrT    idRt;
    logic       memOk;
    logic       wbOk;

    assign opcode = instrId[31:26];
    assign funct  = instrId[5:0];
    assign idRs   = instrId[25:21];
    assign idRt   = instrId[20:16];

    ////////////////////////////////////////////////////////////
    // Instruction decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        ctrl = '0;                           // Unknown encodings stay inert
        case (opcode)
            OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDstRd = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.aluOp = ALU_ADD;
                    FN_SUBU: ctrl.aluOp = ALU_SUB;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    default: ctrl = '0;      // Includes the all-zero NOP
                endcase
            end
            OP_ADDIU: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            OP_ORI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.zeroExt   = 1'b1;
                ctrl.aluOp     = ALU_OR;
            end
            OP_LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;       // Address = rs + offset
            end
            OP_SW: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = (opcode == OP_BNE);
                ctrl.aluOp    = ALU_SUB;
            end
            default: ctrl = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Hazards
    ////////////////////////////////////////////////////////////
    // Load in EX feeding the instruction in decode, one bubble
    assign stall = exMemRead && (exRt != '0) && ((exRt == idRs) || (exRt == idRt));
    assign flush = branchTaken;              // Kill IF/ID and ID/EX

    // A pending load in MEM has no data yet, never forward it
    assign memOk = memBus.regWrite && !memBus.memRead && (memBus.dest != '0);
    assign wbOk  = wbBus.regWrite && (wbBus.dest != '0);

    // Youngest producer wins
    assign fwdSelA = (memOk && memBus.dest == exRs) ? FWD_MEM :
                     (wbOk && wbBus.dest == exRs)   ? FWD_WB  : FWD_REG;
    assign fwdSelB = (memOk && memBus.dest == exRt) ? FWD_MEM :
                     (wbOk && wbBus.dest == exRt)   ? FWD_WB  : FWD_REG;

endmodule
